/* ibus_subsys_top.f */
+incdir+source
source/ibus_pkg.sv
source/ibus_ctrler.sv
source/dbus_ctrler.sv
source/icb_arbiter.sv
source/icb_sram.sv
source/ibus_subsys_top.sv
sim/ibus_assertions.sv
sim/tb_ibus_subsys.sv

/* sim/ibus_assertions.sv */
`timescale 1ns/1ps

module ibus_assertions
	import ibus_pkg::*;
(
	input logic clk,
	input logic resetn,
	input logic imem_req_ready,
	input imem_resp_t imem_resp,
	input logic imem_resp_valid,
	input icb_cmd_t icb_cmd,
	input logic icb_cmd_valid,
	input logic icb_cmd_ready,
	input logic [1:0] n_outstanding
);

	logic timed_out; // timeout response already seen

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			timed_out <= 1'b0;
		else if (imem_resp_valid && (imem_resp.err == imem_timeout))
			timed_out <= 1'b1;
	end

	// a refused command stays up with the same payload unless the timeout ends it
	cmd_held_until_ready: assert property (@(posedge clk) disable iff (!resetn)
		(icb_cmd_valid && !icb_cmd_ready) |=> (icb_cmd_valid && $stable(icb_cmd))
			|| (imem_resp_valid && (imem_resp.err == imem_timeout)))
		else $error("fetch command dropped or changed before the bus took it");

	max_two_outstanding: assert property (@(posedge clk) disable iff (!resetn)
		n_outstanding != 2'b11)
		else $error("more than two fetches outstanding");

	locked_after_timeout: assert property (@(posedge clk) disable iff (!resetn)
		timed_out |-> !imem_req_ready)
		else $error("instruction request port ready again after a timeout");

endmodule

bind ibus_ctrler ibus_assertions u_assertions (
	.clk(clk),
	.resetn(resetn),
	.imem_req_ready(imem_req_ready),
	.imem_resp(imem_resp),
	.imem_resp_valid(imem_resp_valid),
	.icb_cmd(icb_cmd),
	.icb_cmd_valid(icb_cmd_valid),
	.icb_cmd_ready(icb_cmd_ready),
	.n_outstanding(n_outstanding)
);

/* sim/ibus_stimulus.txt */
// test port op addr size uns wdata expdata experr (addr and data in hex)
// port 0 fetch, 1 data; op 0 read file data, 1 read stored data, 2 write file data, 3 write random
1 1 2 00000100 2 0 a5c3e781 00000000 0
1 1 0 00000100 2 0 00000000 a5c3e781 0
1 1 0 00000100 0 0 00000000 ffffff81 0
1 1 0 00000101 0 0 00000000 ffffffe7 0
1 1 0 00000101 0 1 00000000 000000e7 0
1 1 0 00000102 1 0 00000000 ffffa5c3 0
1 1 0 00000102 1 1 00000000 0000a5c3 0
1 1 2 00000103 0 0 0000007f 00000000 0
1 1 0 00000100 2 0 00000000 7fc3e781 0
1 1 2 00000106 1 0 00008001 00000000 0
1 1 0 00000106 1 0 00000000 ffff8001 0
1 1 0 00000106 1 1 00000000 00008001 0
1 1 3 00000108 2 0 00000000 00000000 0
1 1 3 0000010c 1 0 00000000 00000000 0
1 1 3 0000010e 0 0 00000000 00000000 0
1 1 1 0000010e 0 0 00000000 00000000 0
1 1 1 0000010c 1 1 00000000 00000000 0
1 1 1 00000108 1 0 00000000 00000000 0
1 1 1 0000010a 0 0 00000000 00000000 0
2 0 1 00000100 2 0 00000000 00000000 0
2 0 1 00000108 2 0 00000000 00000000 0
3 0 0 00000102 2 0 00000000 00000000 1
3 0 1 00000100 2 0 00000000 00000000 0
3 0 0 00000106 2 0 00000000 00000000 1
3 1 0 00000101 1 0 00000000 00000000 1
3 1 2 00000102 2 0 12345678 00000000 1
4 0 0 80000000 2 0 00000000 00000000 2
4 1 0 80000010 2 0 00000000 00000000 2
4 1 2 80000014 0 0 00000012 00000000 2
5 0 1 00000100 2 0 00000000 00000000 0
5 1 3 00000200 2 0 00000000 00000000 0
5 0 1 00000108 2 0 00000000 00000000 0
5 1 1 00000200 2 0 00000000 00000000 0
5 0 1 00000100 2 0 00000000 00000000 0
5 1 0 00000101 0 1 00000000 000000e7 0
6 0 0 90000000 2 0 00000000 00000000 3

/* sim/tb_ibus_subsys.sv */
`timescale 1ns/1ps

module tb_ibus_subsys
	import ibus_pkg::*;
();

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] err;
		logic chk; // compare read data as well
		logic [3:0] test;
		logic [7:0] idx;
	} exp_t;

	localparam int max_lines = 64;

	logic clk;
	logic resetn;
	imem_req_t imem_req;
	logic imem_req_valid;
	logic imem_req_ready;
	imem_resp_t imem_resp;
	logic imem_resp_valid;
	dmem_req_t dmem_req;
	logic dmem_req_valid;
	logic dmem_req_ready;
	dmem_resp_t dmem_resp;
	logic dmem_resp_valid;

	// one entry per stimulus line
	int n_lines;
	int l_test [max_lines];
	int l_port [max_lines];
	int l_op [max_lines];
	int l_size [max_lines];
	int l_uns [max_lines];
	logic [31:0] l_addr [max_lines];
	logic [31:0] l_wdata [max_lines];
	exp_t l_exp [max_lines];

	logic [7:0] model_mem [logic [31:0]]; // byte image of all stores
	logic [31:0] rng_state = 32'h74bb;
	exp_t iq [$];
	exp_t dq [$];
	string names [7];
	int test_err [7];
	int cur_test;
	int n_errors;
	int cycles;
	int limit;

	ibus_subsys_top dut (
		.clk(clk),
		.resetn(resetn),
		.imem_req(imem_req),
		.imem_req_valid(imem_req_valid),
		.imem_req_ready(imem_req_ready),
		.imem_resp(imem_resp),
		.imem_resp_valid(imem_resp_valid),
		.dmem_req(dmem_req),
		.dmem_req_valid(dmem_req_valid),
		.dmem_req_ready(dmem_req_ready),
		.dmem_resp(dmem_resp),
		.dmem_resp_valid(dmem_resp_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// store data sits in the low bytes
	// size 0/1/2 means 1/2/4 bytes
	function automatic void model_write(logic [31:0] addr, int size, logic [31:0] data);
		for (int b = 0; b < (1 << size); b++)
			model_mem[addr + b] = data[b*8 +: 8];
	endfunction

	function automatic logic [31:0] model_read(logic [31:0] addr, int size, int uns);
		logic [31:0] word;
		word = '0;
		for (int b = 0; b < (1 << size); b++)
			word[b*8 +: 8] = model_mem[addr + b];
		if (size == 0 && uns == 0)
			word[31:8] = {24{word[7]}};
		else if (size == 1 && uns == 0)
			word[31:16] = {16{word[15]}};
		return word;
	endfunction

	task automatic note_error(int t);
		test_err[t]++;
		n_errors++;
	endtask

	task automatic read_stimulus();
		int fd;
		int n;
		int t, p, op, sz, u, e;
		logic [31:0] a, wd, xd;
		string line;
		n_lines = 0;
		fd = $fopen("sim/ibus_stimulus.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd) && n_lines < max_lines)
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "/")
					continue;
				n = $sscanf(line, "%d %d %d %h %d %d %h %h %d", t, p, op, a, sz, u, wd, xd, e);
				if (n != 9)
					continue;
				if (op == 1)
					xd = model_read(a, (p == 0) ? 2 : sz, u); // fetches read whole words
				else if (op == 3)
					wd = next_random();
				if (op >= 2 && e == 0)
					model_write(a, sz, wd);
				l_test[n_lines] = t;
				l_port[n_lines] = p;
				l_op[n_lines] = op;
				l_size[n_lines] = sz;
				l_uns[n_lines] = u;
				l_addr[n_lines] = a;
				l_wdata[n_lines] = wd;
				l_exp[n_lines] = '{data: xd, err: 2'(e), chk: (op <= 1 && e == 0),
					test: 4'(t), idx: 8'(n_lines)};
				n_lines++;
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_imem(int t);
		for (int i = 0; i < n_lines; i++)
		begin
			if (l_test[i] != t || l_port[i] != 0)
				continue;
			imem_req.addr = l_addr[i];
			imem_req.read = 1'b1;
			imem_req.wdata = '0;
			imem_req.wmask = '0;
			imem_req_valid = 1'b1;
			iq.push_back(l_exp[i]);
			@(negedge clk);
			while (!imem_req_ready)
				@(negedge clk);
			@(posedge clk);
			#1;
		end
		imem_req_valid = 1'b0;
	endtask

	task automatic drive_dmem(int t);
		for (int i = 0; i < n_lines; i++)
		begin
			if (l_test[i] != t || l_port[i] != 1)
				continue;
			dmem_req.addr = l_addr[i];
			dmem_req.read = (l_op[i] <= 1);
			dmem_req.size = mem_size_t'(l_size[i]);
			dmem_req.uns = l_uns[i][0];
			dmem_req.wdata = l_wdata[i];
			dmem_req_valid = 1'b1;
			dq.push_back(l_exp[i]);
			@(negedge clk);
			while (!dmem_req_ready)
				@(negedge clk);
			@(posedge clk);
			#1;
		end
		dmem_req_valid = 1'b0;
	endtask

	// both ports run in parallel, then all responses drain
	task automatic run_test(int t);
		cur_test = t;
		fork
			drive_imem(t);
			drive_dmem(t);
		join
		while (iq.size() != 0 || dq.size() != 0)
			@(posedge clk);
	endtask

	task automatic hold_after_timeout();
		#1;
		imem_req.addr = 32'h0000_0100;
		imem_req_valid = 1'b1; // aligned fetch that must never be taken
		repeat (20)
		begin
			@(negedge clk);
			if (imem_req_ready)
			begin
				$display("%s: instruction port became ready again after the timeout", names[6]);
				note_error(6);
			end
		end
		imem_req_valid = 1'b0;
	endtask

	task automatic check_imem();
		exp_t e;
		if (iq.size() == 0)
		begin
			$display("%s: instruction response arrived with no fetch pending", names[cur_test]);
			note_error(cur_test);
		end
		else
		begin
			e = iq.pop_front();
			if (imem_resp.err !== e.err)
			begin
				$display("FAIL %s access %0d: expected err %0d actual %0d",
					names[e.test], e.idx, e.err, imem_resp.err);
				note_error(e.test);
			end
			else if (e.chk && imem_resp.rdata !== e.data)
			begin
				$display("FAIL %s access %0d: expected data %h actual %h",
					names[e.test], e.idx, e.data, imem_resp.rdata);
				note_error(e.test);
			end
		end
	endtask

	task automatic check_dmem();
		exp_t e;
		logic [1:0] err;
		err = {dmem_resp.bus_err, dmem_resp.misaligned}; // 1 misaligned, 2 bus error
		if (dq.size() == 0)
		begin
			$display("%s: data response arrived with no access pending", names[cur_test]);
			note_error(cur_test);
		end
		else
		begin
			e = dq.pop_front();
			if (err !== e.err)
			begin
				$display("FAIL %s access %0d: expected err %0d actual %0d",
					names[e.test], e.idx, e.err, err);
				note_error(e.test);
			end
			else if (e.chk && dmem_resp.rdata !== e.data)
			begin
				$display("FAIL %s access %0d: expected data %h actual %h",
					names[e.test], e.idx, e.data, dmem_resp.rdata);
				note_error(e.test);
			end
		end
	endtask

	// responses are stable half a cycle after the inputs change
	always @(negedge clk)
	begin
		if (resetn && imem_resp_valid)
			check_imem();
		if (resetn && dmem_resp_valid)
			check_dmem();
	end

	initial
	begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("responses never arrived within %0d cycles", limit);
		$display("test failed");
		$finish;
	end

	initial
	begin
		int n_pass;
		int n_fail;
		imem_req = '0;
		imem_req_valid = 1'b0;
		dmem_req = '0;
		dmem_req_valid = 1'b0;
		resetn = 1'b0;
		n_errors = 0;
		cur_test = 0;
		names[0] = "setup";
		names[1] = "data_sizes";
		names[2] = "fetch_stored";
		names[3] = "misaligned";
		names[4] = "error_window";
		names[5] = "both_ports";
		names[6] = "fetch_hang";
		for (int t = 0; t < 7; t++)
			test_err[t] = 0;
		read_stimulus();
		limit = 40 * n_lines + 100;
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		if (n_lines == 0)
		begin
			$display("no accesses could be read from sim/ibus_stimulus.txt");
			note_error(0);
		end
		else
		begin
			for (int t = 1; t <= 6; t++)
			begin
				@(posedge clk);
				#1;
				run_test(t);
				if (t == 6)
					hold_after_timeout(); // hang test runs last
				if (test_err[t] == 0)
					$display("%s: ok", names[t]);
				else
					$display("%s: %0d errors", names[t], test_err[t]);
			end
		end
		n_pass = 0;
		n_fail = 0;
		for (int t = 1; t <= 6; t++)
			if (test_err[t] == 0)
				n_pass++;
			else
				n_fail++;
		$display("tests clean %0d, tests with errors %0d, errors %0d", n_pass, n_fail, n_errors);
		if (n_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* source/dbus_ctrler.sv */
`timescale 1ns/1ps

module dbus_ctrler
	import ibus_pkg::*;
(
	input logic clk,
	input logic resetn,

	input dmem_req_t dmem_req,
	input logic dmem_req_valid,
	output logic dmem_req_ready,

	output dmem_resp_t dmem_resp,
	output logic dmem_resp_valid,

	output icb_cmd_t icb_cmd,
	output logic icb_cmd_valid,
	input logic icb_cmd_ready,

	input icb_rsp_t icb_rsp,
	input logic icb_rsp_valid,
	output logic icb_rsp_ready
);

	logic aligned;
	logic busy; // one access on the bus
	logic [1:0] off;
	logic [1:0] off_q;
	mem_size_t size_q;
	logic uns_q;
	logic [31:0] lane;
	logic [3:0] mask;
	logic misaligned_resp;

	assign off = dmem_req.addr[1:0];

	always_comb
	begin
		case (dmem_req.size)
			size_byte:
			begin
				aligned = 1'b1;
				mask = 4'b0001 << off;
			end
			size_half:
			begin
				aligned = ~off[0];
				mask = 4'b0011 << off;
			end
			default:
			begin
				aligned = (off == 2'b00);
				mask = 4'b1111;
			end
		endcase
	end

	assign icb_cmd.addr = {dmem_req.addr[31:2], 2'b00};
	assign icb_cmd.read = dmem_req.read;
	assign icb_cmd.wdata = dmem_req.wdata << {off, 3'b000}; // into its byte lane
	assign icb_cmd.wmask = mask;

	assign icb_cmd_valid = dmem_req_valid & ~busy & aligned;
	assign dmem_req_ready = ~busy & (~aligned | icb_cmd_ready);
	assign misaligned_resp = dmem_req_valid & ~busy & ~aligned;
	assign icb_rsp_ready = busy;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			busy <= 1'b0;
		else if (icb_cmd_valid & icb_cmd_ready)
			busy <= 1'b1;
		else if (icb_rsp_valid)
			busy <= 1'b0;
	end

	// load format of the access in flight
	always_ff @(posedge clk)
	begin
		if (icb_cmd_valid & icb_cmd_ready)
		begin
			off_q <= off;
			size_q <= dmem_req.size;
			uns_q <= dmem_req.uns;
		end
	end

	assign lane = icb_rsp.rdata >> {off_q, 3'b000};
	assign dmem_resp_valid = (busy & icb_rsp_valid) | misaligned_resp;
	assign dmem_resp.misaligned = misaligned_resp;
	assign dmem_resp.bus_err = busy & icb_rsp.err;

	always_comb
	begin
		if (misaligned_resp)
			dmem_resp.rdata = '0;
		else
			case (size_q)
				size_byte: dmem_resp.rdata = {{24{~uns_q & lane[7]}}, lane[7:0]};
				size_half: dmem_resp.rdata = {{16{~uns_q & lane[15]}}, lane[15:0]};
				default: dmem_resp.rdata = lane;
			endcase
	end

endmodule

/* source/ibus_ctrler.sv */
`timescale 1ns/1ps
`include "ibus_defines.svh"

module ibus_ctrler
	import ibus_pkg::*;
(
	input logic clk,
	input logic resetn,

	input imem_req_t imem_req,
	input logic imem_req_valid,
	output logic imem_req_ready,

	output imem_resp_t imem_resp,
	output logic imem_resp_valid,

	output icb_cmd_t icb_cmd,
	output logic icb_cmd_valid,
	input logic icb_cmd_ready,

	input icb_rsp_t icb_rsp,
	input logic icb_rsp_valid,
	output logic icb_rsp_ready
);

	localparam int to_w = ($clog2(`IMEM_TIMEOUT_TH) > 0) ? $clog2(`IMEM_TIMEOUT_TH) : 1;

	logic pc_aligned;
	logic trans_start; // request accepted
	logic trans_finish; // any response returned
	logic clr_all;
	logic [1:0] n_outstanding;
	logic outstanding;
	logic direct_unaligned; // misaligned with nothing in flight

	// misalignment record queue with one-hot pointers
	logic [1:0] unaligned_q;
	logic [1:0] q_wptr;
	logic [1:0] q_rptr;
	logic q_wen;
	logic q_ren;
	logic head_unaligned;

	logic [to_w-1:0] to_cnt;
	logic to_lock; // stays set until reset
	logic to_pulse;
	logic to_expire;

	logic rsp_fire;
	logic resp_unaligned;

	always_comb
	begin
		if (`INST_ALIGN_W == 16)
			pc_aligned = ~imem_req.addr[0];
		else
			pc_aligned = (imem_req.addr[1:0] == 2'b00);
	end

	assign outstanding = (n_outstanding != 2'b00);
	assign trans_start = imem_req_valid & imem_req_ready;
	assign trans_finish = imem_resp_valid;
	assign clr_all = to_pulse;
	assign direct_unaligned = ~outstanding & ~pc_aligned;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			n_outstanding <= 2'b00;
		else if (clr_all)
			n_outstanding <= 2'b00;
		else if (trans_start & ~trans_finish)
			n_outstanding <= n_outstanding + 2'b01;
		else if (~trans_start & trans_finish)
			n_outstanding <= n_outstanding - 2'b01;
	end

	// same-cycle misaligned answers bypass the queue
	assign q_wen = trans_start & ~direct_unaligned;
	assign q_ren = trans_finish & ~direct_unaligned;
	assign head_unaligned = |(q_rptr & unaligned_q);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			q_wptr <= 2'b01;
			q_rptr <= 2'b01;
		end
		else
		begin
			if (q_wen)
				q_wptr <= {q_wptr[0], q_wptr[1]};
			if (q_ren)
				q_rptr <= {q_rptr[0], q_rptr[1]};
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
			if (q_wen & q_wptr[i])
				unaligned_q[i] <= ~pc_aligned;
	end

	// command goes straight from the request with the address forced aligned
	always_comb
	begin
		icb_cmd.addr = imem_req.addr;
		if (`INST_ALIGN_W == 16)
			icb_cmd.addr[0] = 1'b0;
		else
			icb_cmd.addr[1:0] = 2'b00;
		icb_cmd.read = imem_req.read;
		icb_cmd.wdata = imem_req.wdata;
		icb_cmd.wmask = imem_req.wmask;
	end

	assign icb_cmd_valid = imem_req_valid & ~to_lock & pc_aligned & ~n_outstanding[1];
	assign imem_req_ready = ~to_lock & ~n_outstanding[1] & (~pc_aligned | icb_cmd_ready);

	// timeout counter restarts on every response
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			to_cnt <= '0;
		else if (~to_lock & (outstanding | trans_finish))
			to_cnt <= trans_finish ? '0 : to_cnt + 1'b1;
	end

	assign to_expire = ~to_lock & outstanding & (to_cnt == to_w'(`IMEM_TIMEOUT_TH - 1));

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			to_lock <= 1'b0;
			to_pulse <= 1'b0;
		end
		else
		begin
			if (to_expire)
				to_lock <= 1'b1;
			to_pulse <= to_expire; // single timeout response
		end
	end

	assign rsp_fire = icb_rsp_valid & icb_rsp_ready;
	assign resp_unaligned = ~to_lock & ((outstanding & head_unaligned)
		| (direct_unaligned & imem_req_valid));

	// hold off the bus while a misaligned record sits at the head
	assign icb_rsp_ready = ~to_lock & ~(outstanding & head_unaligned);

	assign imem_resp_valid = rsp_fire | resp_unaligned | to_pulse;
	assign imem_resp.rdata = icb_rsp.rdata;

	always_comb
	begin
		if (to_pulse)
			imem_resp.err = imem_timeout;
		else if (resp_unaligned)
			imem_resp.err = imem_pc_unaligned;
		else if (rsp_fire & icb_rsp.err)
			imem_resp.err = imem_bus_err;
		else
			imem_resp.err = imem_normal;
	end

endmodule

/* source/ibus_defines.svh */
`ifndef IBUS_DEFINES_SVH
`define IBUS_DEFINES_SVH

// cycles an outstanding fetch may wait before a timeout response
`define IMEM_TIMEOUT_TH 16

// instruction alignment in bits, 16 or 32
`define INST_ALIGN_W 32

// on-chip memory depth in 32-bit words
`define MEM_WORDS 256

// address bits 31:28 of the special windows
`define ERR_WINDOW 4'h8 // answers with an error
`define HANG_WINDOW 4'h9 // accepts, never answers

`endif

/* source/ibus_pkg.sv */
package ibus_pkg;

	// ICB command channel payload
	typedef struct packed {
		logic [31:0] addr;
		logic read;
		logic [31:0] wdata;
		logic [3:0] wmask;
	} icb_cmd_t;

	// ICB response channel payload
	typedef struct packed {
		logic [31:0] rdata;
		logic err;
	} icb_rsp_t;

	// instruction memory request
	typedef struct packed {
		logic [31:0] addr;
		logic read;
		logic [31:0] wdata;
		logic [3:0] wmask;
	} imem_req_t;

	typedef enum logic [1:0] {
		imem_normal = 2'b00,
		imem_pc_unaligned = 2'b01,
		imem_bus_err = 2'b10,
		imem_timeout = 2'b11
	} imem_err_t;

	typedef struct packed {
		logic [31:0] rdata;
		imem_err_t err;
	} imem_resp_t;

	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_t;

	// data memory request
	typedef struct packed {
		logic [31:0] addr;
		logic read;
		mem_size_t size;
		logic uns; // zero-extend loads
		logic [31:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic misaligned;
		logic bus_err;
	} dmem_resp_t;

endpackage

/* source/ibus_subsys_top.sv */
`timescale 1ns/1ps

module ibus_subsys_top
	import ibus_pkg::*;
(
	input logic clk,
	input logic resetn,

	input imem_req_t imem_req,
	input logic imem_req_valid,
	output logic imem_req_ready,
	output imem_resp_t imem_resp,
	output logic imem_resp_valid,

	input dmem_req_t dmem_req,
	input logic dmem_req_valid,
	output logic dmem_req_ready,
	output dmem_resp_t dmem_resp,
	output logic dmem_resp_valid
);

	// instruction side, master 0
	icb_cmd_t i_cmd;
	logic i_cmd_valid;
	logic i_cmd_ready;
	icb_rsp_t i_rsp;
	logic i_rsp_valid;
	logic i_rsp_ready;

	// data side, master 1
	icb_cmd_t d_cmd;
	logic d_cmd_valid;
	logic d_cmd_ready;
	icb_rsp_t d_rsp;
	logic d_rsp_valid;
	logic d_rsp_ready;

	icb_cmd_t s_cmd;
	logic s_cmd_valid;
	logic s_cmd_ready;
	icb_rsp_t s_rsp;
	logic s_rsp_valid;
	logic s_rsp_ready;

	ibus_ctrler u_ibus (
		.clk(clk),
		.resetn(resetn),
		.imem_req(imem_req),
		.imem_req_valid(imem_req_valid),
		.imem_req_ready(imem_req_ready),
		.imem_resp(imem_resp),
		.imem_resp_valid(imem_resp_valid),
		.icb_cmd(i_cmd),
		.icb_cmd_valid(i_cmd_valid),
		.icb_cmd_ready(i_cmd_ready),
		.icb_rsp(i_rsp),
		.icb_rsp_valid(i_rsp_valid),
		.icb_rsp_ready(i_rsp_ready)
	);

	dbus_ctrler u_dbus (
		.clk(clk),
		.resetn(resetn),
		.dmem_req(dmem_req),
		.dmem_req_valid(dmem_req_valid),
		.dmem_req_ready(dmem_req_ready),
		.dmem_resp(dmem_resp),
		.dmem_resp_valid(dmem_resp_valid),
		.icb_cmd(d_cmd),
		.icb_cmd_valid(d_cmd_valid),
		.icb_cmd_ready(d_cmd_ready),
		.icb_rsp(d_rsp),
		.icb_rsp_valid(d_rsp_valid),
		.icb_rsp_ready(d_rsp_ready)
	);

	icb_arbiter u_arb (
		.clk(clk),
		.resetn(resetn),
		.m0_cmd(i_cmd),
		.m0_cmd_valid(i_cmd_valid),
		.m0_cmd_ready(i_cmd_ready),
		.m0_rsp(i_rsp),
		.m0_rsp_valid(i_rsp_valid),
		.m0_rsp_ready(i_rsp_ready),
		.m1_cmd(d_cmd),
		.m1_cmd_valid(d_cmd_valid),
		.m1_cmd_ready(d_cmd_ready),
		.m1_rsp(d_rsp),
		.m1_rsp_valid(d_rsp_valid),
		.m1_rsp_ready(d_rsp_ready),
		.s_cmd(s_cmd),
		.s_cmd_valid(s_cmd_valid),
		.s_cmd_ready(s_cmd_ready),
		.s_rsp(s_rsp),
		.s_rsp_valid(s_rsp_valid),
		.s_rsp_ready(s_rsp_ready)
	);

	icb_sram u_sram (
		.clk(clk),
		.resetn(resetn),
		.s_cmd(s_cmd),
		.s_cmd_valid(s_cmd_valid),
		.s_cmd_ready(s_cmd_ready),
		.s_rsp(s_rsp),
		.s_rsp_valid(s_rsp_valid),
		.s_rsp_ready(s_rsp_ready)
	);

endmodule

/* source/icb_arbiter.sv */
`timescale 1ns/1ps

module icb_arbiter
	import ibus_pkg::*;
(
	input logic clk,
	input logic resetn,

	input icb_cmd_t m0_cmd,
	input logic m0_cmd_valid,
	output logic m0_cmd_ready,
	output icb_rsp_t m0_rsp,
	output logic m0_rsp_valid,
	input logic m0_rsp_ready,

	input icb_cmd_t m1_cmd,
	input logic m1_cmd_valid,
	output logic m1_cmd_ready,
	output icb_rsp_t m1_rsp,
	output logic m1_rsp_valid,
	input logic m1_rsp_ready,

	output icb_cmd_t s_cmd,
	output logic s_cmd_valid,
	input logic s_cmd_ready,
	input icb_rsp_t s_rsp,
	input logic s_rsp_valid,
	output logic s_rsp_ready
);

	logic pref; // master with priority next
	logic sel;
	logic sel_rr;
	logic hold; // stalled grant is kept
	logic hold_sel;
	logic cmd_fire;
	logic rsp_fire;

	// grant order queue
	logic ord_q [2];
	logic wptr;
	logic rptr;
	logic [1:0] q_cnt;
	logic q_full;
	logic q_empty;
	logic head;

	assign q_full = (q_cnt == 2'd2);
	assign q_empty = (q_cnt == 2'd0);
	assign sel_rr = pref ? m1_cmd_valid : ~m0_cmd_valid;
	assign sel = hold ? hold_sel : sel_rr;

	assign s_cmd = sel ? m1_cmd : m0_cmd;
	assign s_cmd_valid = ~q_full & (m0_cmd_valid | m1_cmd_valid);
	assign m0_cmd_ready = ~q_full & ~sel & s_cmd_ready;
	assign m1_cmd_ready = ~q_full & sel & s_cmd_ready;
	assign cmd_fire = s_cmd_valid & s_cmd_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pref <= 1'b0;
			hold <= 1'b0;
			hold_sel <= 1'b0;
		end
		else
		begin
			if (cmd_fire)
				pref <= ~sel;
			hold <= s_cmd_valid & ~s_cmd_ready;
			hold_sel <= sel;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_fire)
			ord_q[wptr] <= sel;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wptr <= 1'b0;
			rptr <= 1'b0;
			q_cnt <= 2'd0;
		end
		else
		begin
			if (cmd_fire)
				wptr <= ~wptr;
			if (rsp_fire)
				rptr <= ~rptr;
			q_cnt <= q_cnt + {1'b0, cmd_fire} - {1'b0, rsp_fire};
		end
	end

	// oldest grant owns the response
	assign head = ord_q[rptr];
	assign m0_rsp = s_rsp;
	assign m1_rsp = s_rsp;
	assign m0_rsp_valid = s_rsp_valid & ~q_empty & ~head;
	assign m1_rsp_valid = s_rsp_valid & ~q_empty & head;
	assign s_rsp_ready = ~q_empty & (head ? m1_rsp_ready : m0_rsp_ready);
	assign rsp_fire = s_rsp_valid & s_rsp_ready;

endmodule

/* source/icb_sram.sv */
`timescale 1ns/1ps
`include "ibus_defines.svh"

module icb_sram
	import ibus_pkg::*;
(
	input logic clk,
	input logic resetn,

	input icb_cmd_t s_cmd,
	input logic s_cmd_valid,
	output logic s_cmd_ready,

	output icb_rsp_t s_rsp,
	output logic s_rsp_valid,
	input logic s_rsp_ready
);

	localparam int aw = $clog2(`MEM_WORDS);

	logic [31:0] mem [`MEM_WORDS];
	logic [aw-1:0] idx;
	logic cmd_fire;
	logic is_err;
	logic is_hang;
	logic mem_wen;

	assign idx = s_cmd.addr[aw+1:2];
	assign is_err = (s_cmd.addr[31:28] == `ERR_WINDOW);
	assign is_hang = (s_cmd.addr[31:28] == `HANG_WINDOW);

	// free once the held response is taken
	assign s_cmd_ready = ~s_rsp_valid | s_rsp_ready;
	assign cmd_fire = s_cmd_valid & s_cmd_ready;
	assign mem_wen = cmd_fire & ~s_cmd.read & ~is_err & ~is_hang;

	always_ff @(posedge clk)
	begin
		if (mem_wen)
		begin
			for (int b = 0; b < 4; b++)
				if (s_cmd.wmask[b])
					mem[idx][b*8 +: 8] <= s_cmd.wdata[b*8 +: 8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_fire)
		begin
			s_rsp.rdata <= is_err ? 32'd0 : mem[idx]; // old data on a write
			s_rsp.err <= is_err;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			s_rsp_valid <= 1'b0;
		else if (cmd_fire)
			s_rsp_valid <= ~is_hang; // hang window never answers
		else if (s_rsp_ready)
			s_rsp_valid <= 1'b0;
	end

endmodule
